/* logic/glay_pkg.sv */
package glay_pkg;

  // ----------------------------------------------------------
  // Address and vertex widths
  // ----------------------------------------------------------

  // Byte address on the read address channel
  localparam int addr_bits = 64;

  // Vertex index carried by one request
  localparam int vertex_bits = 32;

  // One 64-byte line per vertex
  localparam int vertex_shift = 6;

  // ----------------------------------------------------------
  // Request sources
  // ----------------------------------------------------------

  localparam int num_sources = 2;

  // Source id, also driven onto arid
  localparam int src_bits = 1;

  // ----------------------------------------------------------
  // Request FIFO
  // ----------------------------------------------------------

  localparam int fifo_depth = 8;
  localparam int fifo_ptr_bits = 3;

  // Busy window right after reset, no writes accepted
  localparam int fifo_reset_busy_cycles = 16;

  // ----------------------------------------------------------
  // Run timer
  // ----------------------------------------------------------

  // Done once the timer goes past this count
  localparam int done_timeout_cycles = 2000;
  localparam int timer_bits = 12;

  // ----------------------------------------------------------
  // Types
  // ----------------------------------------------------------

  // Granted request, tagged with its source
  typedef struct packed {
    logic [src_bits-1:0]    src;
    logic [vertex_bits-1:0] vertex;
  } glay_req_t;

  // Controller states
  typedef enum logic [1:0] {
    state_setup = 2'd0,
    state_idle  = 2'd1,
    state_busy  = 2'd2,
    state_done  = 2'd3
  } ctrl_state_t;

endpackage : glay_pkg

/* logic/glay_control_regs.sv */
module glay_control_regs (
  input  logic                           ap_clk,
  input  logic                           m_axi_areset,
  // From the host
  input  logic                           glay_start,
  input  logic                           glay_continue,
  input  logic                           descriptor_valid,
  input  logic [glay_pkg::addr_bits-1:0] descriptor_base,
  // From the controller
  input  logic                           ctrl_ready,
  input  logic                           ctrl_idle,
  input  logic                           ctrl_done,
  // To the host
  output logic                           glay_ready,
  output logic                           glay_idle,
  output logic                           glay_done,
  // To the controller and request FIFO
  output logic                           start_reg,
  output logic                           continue_reg,
  output logic                           desc_valid_reg,
  output logic [glay_pkg::addr_bits-1:0] desc_base_reg
);

  // ----------------------------------------------------------
  // Inbound control and descriptor valid
  // ----------------------------------------------------------

  always_ff @(posedge ap_clk) begin
    if (m_axi_areset) begin
      start_reg      <= 1'b0;
      continue_reg   <= 1'b0;
      desc_valid_reg <= 1'b0;
    end else begin
      start_reg      <= glay_start;
      continue_reg   <= glay_continue;
      desc_valid_reg <= descriptor_valid;
    end
  end

  // Graph base address
  // Follows the host while the descriptor is valid, then holds
  always_ff @(posedge ap_clk) begin
    if (descriptor_valid) begin
      desc_base_reg <= descriptor_base;
    end
  end

  // ----------------------------------------------------------
  // Outbound status
  // ----------------------------------------------------------

  // Unit reports idle straight out of reset
  always_ff @(posedge ap_clk) begin
    if (m_axi_areset) begin
      glay_ready <= 1'b0;
      glay_idle  <= 1'b1;
      glay_done  <= 1'b0;
    end else begin
      glay_ready <= ctrl_ready;
      glay_idle  <= ctrl_idle;
      glay_done  <= ctrl_done;
    end
  end

endmodule : glay_control_regs

/* logic/glay_kernel_control.sv */
module glay_kernel_control (
  input  logic ap_clk,
  input  logic m_axi_areset,
  // Registered control chain
  input  logic start_reg,
  input  logic continue_reg,
  input  logic desc_valid_reg,
  // FIFO still coming out of reset
  input  logic fifo_rst_busy,
  // Status toward the boundary registers
  output logic ctrl_ready,
  output logic ctrl_idle,
  output logic ctrl_done,
  // Run indication for the arbiter
  output logic busy
);

  glay_pkg::ctrl_state_t state;
  glay_pkg::ctrl_state_t state_next;

  logic [glay_pkg::timer_bits-1:0] run_timer;

  // Busy flag one cycle back, held high by reset
  logic rst_busy_prev;
  logic setup_clear;
  logic start_accept;
  logic timer_expired;

  // Setup ends once busy has been low for a full cycle
  assign setup_clear = ~fifo_rst_busy & ~rst_busy_prev;

  // Start only counts with a valid descriptor
  assign start_accept = (state == glay_pkg::state_idle) & start_reg & desc_valid_reg;

  assign timer_expired =
    run_timer > glay_pkg::done_timeout_cycles[glay_pkg::timer_bits-1:0];

  always_ff @(posedge ap_clk) begin
    if (m_axi_areset) begin
      rst_busy_prev <= 1'b1;
    end else begin
      rst_busy_prev <= fifo_rst_busy;
    end
  end

  // ----------------------------------------------------------
  // State machine
  // ----------------------------------------------------------

  always_ff @(posedge ap_clk) begin
    if (m_axi_areset) begin
      state <= glay_pkg::state_setup;
    end else begin
      state <= state_next;
    end
  end

  always_comb begin
    state_next = state;
    case (state)
      // Start ignored here
      glay_pkg::state_setup: if (setup_clear) state_next = glay_pkg::state_idle;
      glay_pkg::state_idle:  if (start_accept) state_next = glay_pkg::state_busy;
      glay_pkg::state_busy:  if (timer_expired) state_next = glay_pkg::state_done;
      // Done holds until the host continues
      glay_pkg::state_done:  if (continue_reg) state_next = glay_pkg::state_idle;
      default:               state_next = glay_pkg::state_setup;
    endcase
  end

  // ----------------------------------------------------------
  // Run timer
  // ----------------------------------------------------------

  // Counts busy cycles under a valid descriptor, restarts otherwise
  always_ff @(posedge ap_clk) begin
    if (m_axi_areset) begin
      run_timer <= '0;
    end else if ((state != glay_pkg::state_busy) || !desc_valid_reg) begin
      run_timer <= '0;
    end else begin
      run_timer <= run_timer + 1'b1;
    end
  end

  // One-cycle ready pulse, lines up with the move to busy
  always_ff @(posedge ap_clk) begin
    if (m_axi_areset) begin
      ctrl_ready <= 1'b0;
    end else begin
      ctrl_ready <= start_accept;
    end
  end

  // Setup also reads as idle toward the host
  assign ctrl_idle = (state == glay_pkg::state_setup) | (state == glay_pkg::state_idle);
  assign ctrl_done = (state == glay_pkg::state_done);
  assign busy      = (state == glay_pkg::state_busy);

endmodule : glay_kernel_control

/* logic/glay_bus_arbiter.sv */
module glay_bus_arbiter (
  input  logic                             ap_clk,
  input  logic                             m_axi_areset,
  // Busy, FIFO has room and is out of reset
  input  logic                             enable,
  // Held by each source until its grant
  input  logic [glay_pkg::num_sources-1:0] req_valid,
  input  logic [glay_pkg::vertex_bits-1:0] req_vertex_0,
  input  logic [glay_pkg::vertex_bits-1:0] req_vertex_1,
  output logic [glay_pkg::num_sources-1:0] req_grant,
  // Same-cycle write into the request FIFO
  output logic                             grant_valid,
  output glay_pkg::glay_req_t              grant_req
);

  // Source that won the last grant
  logic [glay_pkg::src_bits-1:0] last_winner;
  // Candidate for this cycle
  logic [glay_pkg::src_bits-1:0] pick;

  // ----------------------------------------------------------
  // Round-robin pick
  // ----------------------------------------------------------

  // On a tie the last winner steps aside
  always_comb begin
    if (req_valid[0] && req_valid[1]) begin
      pick = ~last_winner;
    end else if (req_valid[1]) begin
      pick = 1'b1;
    end else begin
      pick = 1'b0;
    end
  end

  // At most one grant per cycle, none while disabled
  always_comb begin
    req_grant = '0;
    if (enable && req_valid[pick]) begin
      req_grant[pick] = 1'b1;
    end
  end

  assign grant_valid = |req_grant;

  // Tag the winner with its source id
  assign grant_req.src    = pick;
  assign grant_req.vertex = pick[0] ? req_vertex_1 : req_vertex_0;

  // ----------------------------------------------------------
  // Last winner
  // ----------------------------------------------------------

  // Starts at source 1 so source 0 takes the first tie
  always_ff @(posedge ap_clk) begin
    if (m_axi_areset) begin
      last_winner <= 1'b1;
    end else if (grant_valid) begin
      last_winner <= pick;
    end
  end

endmodule : glay_bus_arbiter

/* logic/glay_req_fifo.sv */
module glay_req_fifo (
  input  logic                           ap_clk,
  input  logic                           m_axi_areset,
  // Write side from the arbiter
  input  logic                           wr_en,
  input  glay_pkg::glay_req_t            wr_req,
  // Graph base from the descriptor
  input  logic [glay_pkg::addr_bits-1:0] base_addr,
  input  logic                           m_axi_arready,
  output logic                           full,
  output logic                           rst_busy,
  // Read address channel
  output logic                           m_axi_arvalid,
  output logic [glay_pkg::addr_bits-1:0] m_axi_araddr,
  output logic [glay_pkg::src_bits-1:0]  m_axi_arid
);

  // Entry storage
  glay_pkg::glay_req_t mem [glay_pkg::fifo_depth];

  logic [glay_pkg::fifo_ptr_bits-1:0] wr_ptr;
  logic [glay_pkg::fifo_ptr_bits-1:0] rd_ptr;
  logic [glay_pkg::fifo_ptr_bits:0]   count;

  // Reset busy countdown
  logic [$clog2(glay_pkg::fifo_reset_busy_cycles+1)-1:0] busy_cnt;

  logic                wr_fire;
  logic                rd_fire;
  glay_pkg::glay_req_t head;

  // ----------------------------------------------------------
  // Reset busy window
  // ----------------------------------------------------------

  always_ff @(posedge ap_clk) begin
    if (m_axi_areset) begin
      busy_cnt <= glay_pkg::fifo_reset_busy_cycles[$bits(busy_cnt)-1:0];
    end else if (busy_cnt != '0) begin
      busy_cnt <= busy_cnt - 1'b1;
    end
  end

  assign rst_busy = (busy_cnt != '0);

  // ----------------------------------------------------------
  // Storage and pointers
  // ----------------------------------------------------------

  assign full    = (count == glay_pkg::fifo_depth[glay_pkg::fifo_ptr_bits:0]);
  // Writes dropped when full or still in reset busy
  assign wr_fire = wr_en & ~full & ~rst_busy;
  assign rd_fire = m_axi_arvalid & m_axi_arready;

  always_ff @(posedge ap_clk) begin
    if (wr_fire) begin
      mem[wr_ptr] <= wr_req;
    end
  end

  // Pointers wrap on their own at depth 8
  always_ff @(posedge ap_clk) begin
    if (m_axi_areset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (wr_fire) wr_ptr <= wr_ptr + 1'b1;
      if (rd_fire) rd_ptr <= rd_ptr + 1'b1;
      case ({wr_fire, rd_fire})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // ----------------------------------------------------------
  // Read address from the head entry
  // ----------------------------------------------------------

  // Head only moves on a handshake, so address and id hold under stall
  assign head          = mem[rd_ptr];
  assign m_axi_arvalid = (count != '0);
  assign m_axi_araddr  = base_addr +
    ({{(glay_pkg::addr_bits-glay_pkg::vertex_bits){1'b0}}, head.vertex}
     << glay_pkg::vertex_shift);
  assign m_axi_arid    = head.src;

endmodule : glay_req_fifo

/* logic/glay_kernel_cu.sv */
module glay_kernel_cu (
  input  logic                                ap_clk,
  input  logic                                m_axi_areset,
  // Control chain
  input  logic                                glay_start,
  input  logic                                glay_continue,
  output logic                                glay_ready,
  output logic                                glay_idle,
  output logic                                glay_done,
  // Descriptor
  input  logic                                descriptor_valid,
  input  logic [glay_pkg::addr_bits-1:0]      descriptor_base,
  // Vertex request sources
  input  logic [glay_pkg::num_sources-1:0]    req_valid,
  input  logic [glay_pkg::vertex_bits-1:0]    req_vertex_0,
  input  logic [glay_pkg::vertex_bits-1:0]    req_vertex_1,
  output logic [glay_pkg::num_sources-1:0]    req_grant,
  // Read address channel
  output logic                                m_axi_arvalid,
  input  logic                                m_axi_arready,
  output logic [glay_pkg::addr_bits-1:0]      m_axi_araddr,
  output logic [glay_pkg::src_bits-1:0]       m_axi_arid
);

  // ----------------------------------------------------------
  // Internal wires
  // ----------------------------------------------------------

  // Registered control chain and descriptor
  logic                           start_reg;
  logic                           continue_reg;
  logic                           desc_valid_reg;
  logic [glay_pkg::addr_bits-1:0] desc_base_reg;

  // Controller outputs, before the boundary registers
  logic ctrl_ready;
  logic ctrl_idle;
  logic ctrl_done;
  logic busy;

  // Arbiter to FIFO
  logic                arb_enable;
  logic                grant_valid;
  glay_pkg::glay_req_t grant_req;

  // FIFO status
  logic fifo_full;
  logic fifo_rst_busy;

  // Grant only while running and the FIFO can take an entry
  assign arb_enable = busy & ~fifo_full & ~fifo_rst_busy;

  // ----------------------------------------------------------
  // Control path
  // ----------------------------------------------------------

  glay_control_regs control_regs_i (
    .ap_clk          (ap_clk),
    .m_axi_areset    (m_axi_areset),
    .glay_start      (glay_start),
    .glay_continue   (glay_continue),
    .descriptor_valid(descriptor_valid),
    .descriptor_base (descriptor_base),
    .ctrl_ready      (ctrl_ready),
    .ctrl_idle       (ctrl_idle),
    .ctrl_done       (ctrl_done),
    .glay_ready      (glay_ready),
    .glay_idle       (glay_idle),
    .glay_done       (glay_done),
    .start_reg       (start_reg),
    .continue_reg    (continue_reg),
    .desc_valid_reg  (desc_valid_reg),
    .desc_base_reg   (desc_base_reg)
  );

  glay_kernel_control kernel_control_i (
    .ap_clk        (ap_clk),
    .m_axi_areset  (m_axi_areset),
    .start_reg     (start_reg),
    .continue_reg  (continue_reg),
    .desc_valid_reg(desc_valid_reg),
    .fifo_rst_busy (fifo_rst_busy),
    .ctrl_ready    (ctrl_ready),
    .ctrl_idle     (ctrl_idle),
    .ctrl_done     (ctrl_done),
    .busy          (busy)
  );

  // ----------------------------------------------------------
  // Request path
  // ----------------------------------------------------------

  glay_bus_arbiter bus_arbiter_i (
    .ap_clk      (ap_clk),
    .m_axi_areset(m_axi_areset),
    .enable      (arb_enable),
    .req_valid   (req_valid),
    .req_vertex_0(req_vertex_0),
    .req_vertex_1(req_vertex_1),
    .req_grant   (req_grant),
    .grant_valid (grant_valid),
    .grant_req   (grant_req)
  );

  glay_req_fifo req_fifo_i (
    .ap_clk       (ap_clk),
    .m_axi_areset (m_axi_areset),
    .wr_en        (grant_valid),
    .wr_req       (grant_req),
    .base_addr    (desc_base_reg),
    .m_axi_arready(m_axi_arready),
    .full         (fifo_full),
    .rst_busy     (fifo_rst_busy),
    .m_axi_arvalid(m_axi_arvalid),
    .m_axi_araddr (m_axi_araddr),
    .m_axi_arid   (m_axi_arid)
  );

endmodule : glay_kernel_cu

/* tests/glay_kernel_cu_tb.sv */
module glay_kernel_cu_tb;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int clk_period = 8;
  localparam int max_words = 64;
  // Selectors for wait_output
  localparam int out_ready = 0;
  localparam int out_done = 1;
  localparam int out_idle = 2;

  logic                             ap_clk;
  logic                             m_axi_areset;
  logic                             glay_start;
  logic                             glay_continue;
  logic                             glay_ready;
  logic                             glay_idle;
  logic                             glay_done;
  logic                             descriptor_valid;
  logic [glay_pkg::addr_bits-1:0]   descriptor_base;
  logic [glay_pkg::num_sources-1:0] req_valid;
  logic [glay_pkg::vertex_bits-1:0] req_vertex_0;
  logic [glay_pkg::vertex_bits-1:0] req_vertex_1;
  logic [glay_pkg::num_sources-1:0] req_grant;
  logic                             m_axi_arvalid;
  logic                             m_axi_arready;
  logic [glay_pkg::addr_bits-1:0]   m_axi_araddr;
  logic [glay_pkg::src_bits-1:0]    m_axi_arid;

  // Raw pattern words
  logic [63:0] pat_mem [max_words];
  // Vertices still waiting for a grant
  logic [31:0] src_q0 [$];
  logic [31:0] src_q1 [$];
  // Expected read addresses in each source's order
  logic [63:0] exp_q0 [$];
  logic [63:0] exp_q1 [$];

  logic [63:0] base;
  int n_req;
  int seed;
  int errors = 0;
  int tests_run = 0;
  int tests_failed = 0;
  int cycle = 0;
  int ready_pulses = 0;
  int limit_cycles = 0;

  glay_kernel_cu dut_i (.*);

  initial begin
    ap_clk = 1'b0;
    forever #(clk_period / 2) ap_clk = ~ap_clk;
  end

  // Cycle count and ready high cycles for the main flow
  always @(posedge ap_clk) begin
    cycle <= cycle + 1;
    if (glay_ready) begin
      ready_pulses <= ready_pulses + 1;
    end
  end

  // Watchdog
  initial begin
    wait (limit_cycles > 0);
    repeat (limit_cycles) @(posedge ap_clk);
    $display("watchdog ran out after %0d cycles", limit_cycles);
    $display("*** TEST FAILED ***");
    $finish;
  end

  // ----------------------------------------------------------
  // Helpers
  // ----------------------------------------------------------

  task automatic check_value(input string name, input logic [63:0] got,
                             input logic [63:0] exp);
    if (got !== exp) begin
      $display("error at %0d ns: %s is %h, expected %h", $time, name, got, exp);
      errors++;
    end
  endtask

  task automatic report_failure(input string what);
    $display("at %0d ns: %s", $time, what);
    errors++;
  endtask

  task automatic close_test(input string name, input int errors_at_start);
    tests_run++;
    if (errors == errors_at_start) begin
      $display("test %s: ok", name);
    end else begin
      tests_failed++;
      $display("test %s: failed with %0d errors", name, errors - errors_at_start);
    end
  endtask

  // Inputs change 1 ns after the rising edge
  task automatic next_drive();
    @(posedge ap_clk);
    #1;
  endtask

  function automatic logic output_level(input int which);
    case (which)
      out_ready: return glay_ready;
      out_done:  return glay_done;
      default:   return glay_idle;
    endcase
  endfunction

  task automatic wait_output(input int which, input string what, input int limit,
                             output int waited);
    @(negedge ap_clk);
    waited = 1;
    while (!output_level(which) && waited < limit) begin
      @(negedge ap_clk);
      waited++;
    end
    if (!output_level(which)) begin
      report_failure({what, " never went high"});
    end
  endtask

  // Each source shows the head of its own queue
  task automatic present_requests();
    req_valid[0] = (src_q0.size() > 0);
    req_valid[1] = (src_q1.size() > 0);
    req_vertex_0 = (src_q0.size() > 0) ? src_q0[0] : '0;
    req_vertex_1 = (src_q1.size() > 0) ? src_q1[0] : '0;
  endtask

  // Accepted address against the front of its source's queue
  task automatic match_address();
    logic [63:0] exp_addr;
    if (m_axi_arid == 1'b0 && exp_q0.size() > 0) begin
      exp_addr = exp_q0.pop_front();
      check_value("m_axi_araddr", m_axi_araddr, exp_addr);
    end else if (m_axi_arid == 1'b1 && exp_q1.size() > 0) begin
      exp_addr = exp_q1.pop_front();
      check_value("m_axi_araddr", m_axi_araddr, exp_addr);
    end else begin
      report_failure("read address for a source with nothing outstanding");
    end
  endtask

  // ----------------------------------------------------------
  // Request traffic with an initial arready hold
  // ----------------------------------------------------------

  task automatic run_requests(input int hold_cycles);
    int granted;
    int accepted;
    int outstanding;
    int max_out;
    int hold_left;
    int stall_left;
    int waited;
    logic stalled_prev;
    logic [63:0] addr_prev;
    logic [glay_pkg::src_bits-1:0] id_prev;
    logic [glay_pkg::num_sources-1:0] grants_seen;
    granted = 0;
    accepted = 0;
    max_out = 0;
    hold_left = hold_cycles;
    stall_left = 0;
    waited = 0;
    stalled_prev = 1'b0;
    addr_prev = '0;
    id_prev = '0;
    m_axi_arready = 1'b0;
    present_requests();
    while (accepted < n_req && waited < 40 * n_req + hold_cycles) begin
      @(negedge ap_clk);
      waited++;
      grants_seen = req_grant;
      if ((req_grant & ~req_valid) != '0) begin
        report_failure("grant given to a source with no request");
      end
      if (req_grant == 2'b11) begin
        report_failure("two grants in one cycle");
      end
      granted += $countones(req_grant);
      // Head must hold while stalled
      if (stalled_prev) begin
        check_value("m_axi_arvalid", 64'(m_axi_arvalid), 64'd1);
        check_value("m_axi_araddr", m_axi_araddr, addr_prev);
        check_value("m_axi_arid", 64'(m_axi_arid), 64'(id_prev));
      end
      stalled_prev = m_axi_arvalid & ~m_axi_arready;
      addr_prev = m_axi_araddr;
      id_prev = m_axi_arid;
      if (m_axi_arvalid && m_axi_arready) begin
        accepted++;
        match_address();
        // Stall flag of the request just taken
        if (pat_mem[1 + n_req + accepted] != 64'd0) begin
          stall_left = ($random(seed) & 3) + 1;
        end
      end
      outstanding = granted - accepted;
      if (outstanding > glay_pkg::fifo_depth) begin
        report_failure("more requests granted than the FIFO can hold");
      end
      if (outstanding > max_out) begin
        max_out = outstanding;
      end
      next_drive();
      if (grants_seen[0]) begin
        void'(src_q0.pop_front());
      end
      if (grants_seen[1]) begin
        void'(src_q1.pop_front());
      end
      present_requests();
      if (hold_left > 0) begin
        hold_left--;
        m_axi_arready = 1'b0;
      end else if (stall_left > 0) begin
        stall_left--;
        m_axi_arready = 1'b0;
      end else begin
        m_axi_arready = 1'b1;
      end
    end
    if (accepted < n_req) begin
      report_failure("read addresses stopped before every request came out");
    end
    check_value("granted", 64'(granted), 64'(n_req));
    // Hold is long enough to fill the FIFO
    check_value("max_outstanding", 64'(max_out), 64'(glay_pkg::fifo_depth));
    if (exp_q0.size() + exp_q1.size() != 0) begin
      report_failure("some requests never reached the read address channel");
    end
    req_valid = '0;
  endtask

  // ----------------------------------------------------------
  // Main flow
  // ----------------------------------------------------------

  initial begin
    int waited;
    int err_mark;
    int ready_cycle;
    m_axi_areset = 1'b1;
    glay_start = 1'b0;
    glay_continue = 1'b0;
    descriptor_valid = 1'b0;
    descriptor_base = '0;
    req_valid = '0;
    req_vertex_0 = '0;
    req_vertex_1 = '0;
    m_axi_arready = 1'b0;
    seed = 32'h602ff397;
    $readmemh("tests/glay_req_patterns.txt", pat_mem);
    base = pat_mem[0];
    n_req = int'(pat_mem[1][31:0]);
    limit_cycles = 2 * glay_pkg::done_timeout_cycles + 40 * n_req + 200;
    // Expected addresses follow base plus vertex times line size
    for (int i = 0; i < n_req; i++) begin
      if (pat_mem[2 + i][32]) begin
        src_q1.push_back(pat_mem[2 + i][31:0]);
        exp_q1.push_back(base + (64'(pat_mem[2 + i][31:0]) << glay_pkg::vertex_shift));
      end else begin
        src_q0.push_back(pat_mem[2 + i][31:0]);
        exp_q0.push_back(base + (64'(pat_mem[2 + i][31:0]) << glay_pkg::vertex_shift));
      end
    end

    repeat (5) @(posedge ap_clk);
    #1;
    // Start goes up together with reset release
    m_axi_areset = 1'b0;
    glay_start = 1'b1;
    descriptor_valid = 1'b1;
    descriptor_base = base;

    err_mark = errors;
    @(negedge ap_clk);
    check_value("glay_ready", 64'(glay_ready), 64'd0);
    check_value("glay_done", 64'(glay_done), 64'd0);
    check_value("glay_idle", 64'(glay_idle), 64'd1);
    check_value("m_axi_arvalid", 64'(m_axi_arvalid), 64'd0);
    check_value("req_grant", 64'(req_grant), 64'd0);
    wait_output(out_ready, "glay_ready", 200, waited);
    if (1 + waited <= glay_pkg::fifo_reset_busy_cycles) begin
      report_failure("ready came while the FIFO was still in reset busy");
    end
    ready_cycle = cycle;
    close_test("reset", err_mark);

    err_mark = errors;
    next_drive();
    glay_start = 1'b0;
    repeat (3) @(negedge ap_clk);
    check_value("ready_pulses", 64'(ready_pulses), 64'd1);
    check_value("glay_idle", 64'(glay_idle), 64'd0);
    close_test("start", err_mark);

    err_mark = errors;
    next_drive();
    run_requests(4 * glay_pkg::fifo_depth);
    close_test("requests", err_mark);

    err_mark = errors;
    wait_output(out_done, "glay_done", glay_pkg::done_timeout_cycles + 200, waited);
    if (cycle - ready_cycle < glay_pkg::done_timeout_cycles) begin
      report_failure("done rose before the run timer limit");
    end
    // Done holds without continue
    repeat (4) begin
      @(negedge ap_clk);
      check_value("glay_done", 64'(glay_done), 64'd1);
    end
    next_drive();
    glay_continue = 1'b1;
    next_drive();
    glay_continue = 1'b0;
    wait_output(out_idle, "glay_idle", 20, waited);
    check_value("glay_done", 64'(glay_done), 64'd0);
    // Second run
    next_drive();
    glay_start = 1'b1;
    wait_output(out_ready, "glay_ready", 20, waited);
    next_drive();
    glay_start = 1'b0;
    @(negedge ap_clk);
    check_value("ready_pulses", 64'(ready_pulses), 64'd2);
    close_test("done_continue", err_mark);

    $display("tests %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule : glay_kernel_cu_tb

/* tests/glay_req_patterns.txt */
// Word 0 graph base address, word 1 request count
// Then one record per request (bit 32 source id, bits 31:0 vertex), then one stall flag each
0000004000000000
0000000c
// Requests
0_00000003
1_00000007
0_00000011
1_00000020
0_0000002a
1_0000ffff
0_00000100
1_00001234
0_0001f00d
1_0badcafe
0_00abcdef
1_7fffffff
// Stall flags, nonzero gives a random arready gap after that request
0
1
0
0
1
1
0
1
0
0
1
0

/* all.f */
logic/glay_pkg.sv
logic/glay_control_regs.sv
logic/glay_kernel_control.sv
logic/glay_bus_arbiter.sv
logic/glay_req_fifo.sv
logic/glay_kernel_cu.sv
tests/glay_kernel_cu_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build and run with Verilator, then search the log for the pass line
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --top-module glay_kernel_cu_tb -f all.f -o glay_sim > sim.log 2>&1 \
  && ./obj_dir/glay_sim >> sim.log 2>&1 \
  || echo "build or simulation failed" >> sim.log
grep -qxF "*** TEST PASSED ***" sim.log && echo "PASS" || { echo "FAIL, see sim.log"; exit 1; }
